// ==== filelist.f ====
+incdir+hdl
hdl/awg_data_pkg.sv
hdl/awg_ctrl_pkg.sv
hdl/awg_sequencer.sv
hdl/awg_frame_counter.sv
hdl/awg_wave_buffer.sv
hdl/awg_top.sv
test/awg_asserts.sv
test/awg_tb.sv

// ==== Makefile ====
# Verilator build and run of the waveform generator testbench

SIM  = obj_dir/Vawg_tb
SRCS = $(filter-out +incdir+%,$(shell cat filelist.f))

.PHONY: run clean

# pass only when the pass line shows up in the simulator output
run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

# rebuilt only when a source, the header or the file list changes
$(SIM): filelist.f $(SRCS) hdl/awg_params.svh
	verilator --binary --timing --assert -Wno-fatal --top-module awg_tb -f filelist.f

clean:
	rm -rf obj_dir

// ==== test/awg_tb.sv ====
// self-checking testbench for the two-channel waveform generator, table driven
`include "awg_params.svh"

module awg_tb;
  import awg_data_pkg::*;

  localparam int NUM_ROWS = 5;
  localparam int NCH      = `AWG_CHANNELS;

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////
  // per row and channel: frame depth, frames per burst, trigger mode
  localparam int ROW_DEPTH [NUM_ROWS][NCH] = '{'{4, 6}, '{16, 3}, '{5, 5}, '{1, 2}, '{16, 16}};
  localparam int ROW_BURST [NUM_ROWS][NCH] = '{'{2, 1}, '{0, 3}, '{4, 4}, '{3, 2}, '{1, 2}};
  localparam int ROW_MODE  [NUM_ROWS][NCH] = '{'{2, 1}, '{1, 2}, '{0, 2}, '{2, 2}, '{1, 1}};
  // words sent per row, more than the depth sum probes the drop
  localparam int ROW_WORDS [NUM_ROWS] = '{13, 19, 12, 3, 40};
  // cycles from start to the stop edge, 0 lets the burst finish
  localparam int ROW_STOP  [NUM_ROWS] = '{0, 0, 9, 0, 20};

  logic                            dac_clk;
  logic                            dma_reset;
  logic                            depth_valid;
  depth_t     [NCH-1:0]            depth;
  logic                            trig_valid;
  trig_mode_t [NCH-1:0]            trig_mode;
  logic                            burst_valid;
  burst_t     [NCH-1:0]            burst;
  logic                            load_valid;
  sample_t                         load_data;
  logic                            start;
  logic                            stop;
  logic                            config_ready;
  logic                            load_ready;
  sample_t    [NCH-1:0]            sample_out;
  logic       [NCH-1:0]            trigger;

  // waveform words of the current row, first the depth sum are stored
  sample_t row_words [64];
  int      errors      = 0;
  int      cycle_count = 0;
  int      cycle_limit = 0;

  awg_top dut (
    .dac_clk, .dma_reset,
    .depth_valid, .depth, .trig_valid, .trig_mode, .burst_valid, .burst,
    .load_valid, .load_data, .start, .stop,
    .config_ready, .load_ready, .sample_out, .trigger
  );

  initial begin
    dac_clk = 1'b0;
    forever #2 dac_clk = ~dac_clk;
  end

  task automatic fail_run(input string what);
    errors++;
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // run limit, checked every edge
  always @(posedge dac_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      fail_run($sformatf("timeout, no verdict after %0d cycles", cycle_count));
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_trigger(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // zero burst still plays one frame
  function automatic int samples_in_burst(input int r, input int ch);
    return ROW_DEPTH[r][ch] * ((ROW_BURST[r][ch] == 0) ? 1 : ROW_BURST[r][ch]);
  endfunction

  // sample n counted from the first output after start, a stop cuts the burst short
  function automatic bit sample_live(input int r, input int ch, input int n);
    int lim;
    lim = samples_in_burst(r, ch);
    if (ROW_STOP[r] > 0 && ROW_STOP[r] < lim) lim = ROW_STOP[r];
    return (n >= 0) && (n < lim);
  endfunction

  // channel ch holds the words after all lower channels
  function automatic sample_t expected_sample(input int r, input int ch, input int n);
    int base;
    base = 0;
    for (int c = 0; c < ch; c++) base += ROW_DEPTH[r][c];
    if (!sample_live(r, ch, n)) return '0;
    return row_words[base + n % ROW_DEPTH[r][ch]];
  endfunction

  function automatic logic expected_trigger(input int r, input int ch, input int n);
    if (!sample_live(r, ch, n)) return 1'b0;
    if (ROW_MODE[r][ch] == 1) return n == 0;
    if (ROW_MODE[r][ch] == 2) return (n % ROW_DEPTH[r][ch]) == 0;
    return 1'b0;
  endfunction

  // config, load with drain, playback window and return to idle
  function automatic int row_cycles(input int r);
    int total;
    int play_len;
    total    = ROW_DEPTH[r][0] + ROW_DEPTH[r][1];
    play_len = 0;
    for (int ch = 0; ch < NCH; ch++) begin
      if (samples_in_burst(r, ch) > play_len) play_len = samples_in_burst(r, ch);
    end
    if (ROW_STOP[r] > 0) play_len = ROW_STOP[r];
    return ((ROW_WORDS[r] > total + 3) ? ROW_WORDS[r] : total + 3) + play_len + 12;
  endfunction

  task automatic check_idle();
    check_ready("config_ready", config_ready, 1'b1);
    check_ready("load_ready", load_ready, 1'b0);
    for (int ch = 0; ch < NCH; ch++) begin
      check_sample($sformatf("sample_out[%0d]", ch), sample_out[ch], '0);
      check_trigger($sformatf("trigger[%0d]", ch), trigger[ch], 1'b0);
    end
  endtask

  task automatic run_row(input int r);
    int total;
    int nmax;
    int stop_at;
    int last_rel;
    int end_rel;
    int j;
    total   = ROW_DEPTH[r][0] + ROW_DEPTH[r][1];
    stop_at = ROW_STOP[r];
    nmax    = 0;
    for (int ch = 0; ch < NCH; ch++) begin
      if (samples_in_burst(r, ch) > nmax) nmax = samples_in_burst(r, ch);
    end
    for (int i = 0; i < ROW_WORDS[r]; i++) row_words[i] = sample_t'($urandom);
    while (config_ready !== 1'b1) @(negedge dac_clk);
    // all three config fields in one strobe cycle
    @(posedge dac_clk);
    depth_valid <= 1'b1;
    trig_valid  <= 1'b1;
    burst_valid <= 1'b1;
    for (int ch = 0; ch < NCH; ch++) begin
      depth[ch]     <= depth_t'(ROW_DEPTH[r][ch]);
      trig_mode[ch] <= trig_mode_t'(ROW_MODE[r][ch]);
      burst[ch]     <= burst_t'(ROW_BURST[r][ch]);
    end
    @(posedge dac_clk);
    depth_valid <= 1'b0;
    trig_valid  <= 1'b0;
    burst_valid <= 1'b0;
    load_valid  <= 1'b1;
    load_data   <= row_words[0];
    @(negedge dac_clk);
    check_ready("load_ready", load_ready, 1'b1);
    check_ready("config_ready", config_ready, 1'b0);
    // one word per cycle, load_ready drops 2 edges after the last stored word is taken
    j = 1;
    while (j < ROW_WORDS[r] || j <= total + 2) begin
      @(posedge dac_clk);
      load_valid <= (j < ROW_WORDS[r]);
      load_data  <= row_words[j];
      @(negedge dac_clk);
      check_ready("load_ready", load_ready, j <= total + 1);
      check_ready("config_ready", config_ready, 1'b0);
      j++;
    end
    @(posedge dac_clk);
    load_valid <= 1'b0;
    start      <= 1'b1;
    // rel counts edges from the one that samples start
    last_rel = (stop_at > 0) ? stop_at + 4 : nmax + 4;
    end_rel  = (stop_at > 0) ? stop_at : nmax + 2;
    for (int rel = 0; rel <= last_rel; rel++) begin
      @(posedge dac_clk);
      start <= 1'b0;
      stop  <= (stop_at > 0) && (rel == stop_at - 1);
      @(negedge dac_clk);
      check_ready("config_ready", config_ready, rel >= end_rel);
      check_ready("load_ready", load_ready, 1'b0);
      // output after edge rel is sample rel-3
      for (int ch = 0; ch < NCH; ch++) begin
        check_sample($sformatf("sample_out[%0d]", ch), sample_out[ch],
                     expected_sample(r, ch, rel - 3));
        check_trigger($sformatf("trigger[%0d]", ch), trigger[ch],
                      expected_trigger(r, ch, rel - 3));
      end
    end
    while (config_ready !== 1'b1) @(negedge dac_clk);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    int unsigned seed_draw;
    dma_reset   = 1'b1;
    depth_valid = 1'b0;
    depth       = '0;
    trig_valid  = 1'b0;
    trig_mode   = '0;
    burst_valid = 1'b0;
    burst       = '0;
    load_valid  = 1'b0;
    load_data   = '0;
    start       = 1'b0;
    stop        = 1'b0;
    // first draw seeds the generator for the whole run
    seed_draw   = $urandom(95919);
    cycle_limit = 20;
    for (int r = 0; r < NUM_ROWS; r++) cycle_limit += row_cycles(r);
    repeat (2) @(posedge dac_clk);
    dma_reset <= 1'b0;
    @(negedge dac_clk);
    check_idle();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
      check_idle();
    end
    if (errors == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run("checks failed during the run");
    end
  end

endmodule

// ==== test/awg_asserts.sv ====
// concurrent checks on the load and playback handshake levels and trigger alignment
`include "awg_params.svh"

module awg_asserts (
  input logic                                         dac_clk,
  input logic                                         dma_reset,
  input logic                                         config_ready,
  input logic                                         load_ready,
  input logic                                         load_done,
  input logic                                         play_active,
  input logic                     [`AWG_CHANNELS-1:0] trigger,
  input awg_data_pkg::trig_mode_t [`AWG_CHANNELS-1:0] trig_mode
);

  // the word window closes only on the buffer's end of load
  assert property (@(posedge dac_clk) disable iff (dma_reset)
    $fell(load_ready) |-> $past(load_done))
    else $error("load_ready fell without load_done from the buffer");

  // start is only taken once the buffer write has finished
  assert property (@(posedge dac_clk) disable iff (dma_reset)
    $rose(play_active) |-> !$past(load_ready))
    else $error("playback started while load_ready was high");

  ////////////////////////////////////////
  // trigger checks per channel
  ////////////////////////////////////////
  // trigger leaves the pipeline 3 edges after the mode that produced it
  for (genvar ch = 0; ch < `AWG_CHANNELS; ch++) begin : g_trig
    assert property (@(posedge dac_clk) disable iff (dma_reset)
      trigger[ch] |-> ($past(trig_mode[ch], 3) != '0))
      else $error("trigger on channel %0d with trigger mode 0", ch);
  end

endmodule

// top level sees the outputs and the registered modes together
bind awg_top awg_asserts u_asserts (
  .dac_clk(dac_clk), .dma_reset(dma_reset),
  .config_ready(config_ready), .load_ready(load_ready), .load_done(load_done),
  .play_active(play_active),
  .trigger(trigger), .trig_mode(trig_mode_cfg)
);

// ==== hdl/awg_top.sv ====
// two-channel arbitrary waveform generator top level
`include "awg_params.svh"

module awg_top (
  input  logic                                           dac_clk,
  input  logic                                           dma_reset,
  input  logic                                           depth_valid,
  input  awg_data_pkg::depth_t     [`AWG_CHANNELS-1:0]   depth,
  input  logic                                           trig_valid,
  input  awg_data_pkg::trig_mode_t [`AWG_CHANNELS-1:0]   trig_mode,
  input  logic                                           burst_valid,
  input  awg_data_pkg::burst_t     [`AWG_CHANNELS-1:0]   burst,
  input  logic                                           load_valid,
  input  awg_data_pkg::sample_t                          load_data,
  input  logic                                           start,
  input  logic                                           stop,
  output logic                                           config_ready,
  output logic                                           load_ready,
  output awg_data_pkg::sample_t    [`AWG_CHANNELS-1:0]   sample_out,
  output logic                     [`AWG_CHANNELS-1:0]   trigger
);
  import awg_data_pkg::*;

  // registered config, already minus one
  addr_t      [`AWG_CHANNELS-1:0] addr_max;
  burst_t     [`AWG_CHANNELS-1:0] burst_max;
  trig_mode_t [`AWG_CHANNELS-1:0] trig_mode_cfg;
  logic                           play_active;
  logic                           load_done;
  logic                           play_done;
  // read side, aligned with the address cycle
  addr_t      [`AWG_CHANNELS-1:0] read_addr;
  logic       [`AWG_CHANNELS-1:0] chan_done;
  logic       [`AWG_CHANNELS-1:0] trig_early;

  awg_sequencer u_sequencer (
    .dac_clk, .dma_reset,
    .depth_valid, .depth,
    .trig_valid, .trig_mode_in(trig_mode),
    .burst_valid, .burst,
    .start, .stop, .load_done, .play_done,
    .config_ready, .load_ready, .play_active,
    .addr_max, .burst_max, .trig_mode(trig_mode_cfg)
  );

  awg_frame_counter u_frame_counter (
    .dac_clk, .dma_reset, .play_active,
    .addr_max, .burst_max, .trig_mode(trig_mode_cfg),
    .read_addr, .chan_done, .trig_early, .play_done
  );

  awg_wave_buffer u_wave_buffer (
    .dac_clk, .dma_reset,
    .load_ready, .load_valid, .load_data,
    .addr_max, .read_addr, .chan_done, .trig_early, .play_active,
    .load_done, .sample_out, .trigger
  );

endmodule

// ==== hdl/awg_wave_buffer.sv ====
// channel sample memories with the load write pointer and the output read pipeline
`include "awg_params.svh"

module awg_wave_buffer (
  input  logic                                         dac_clk,
  input  logic                                         dma_reset,
  input  logic                                         load_ready,
  input  logic                                         load_valid,
  input  awg_data_pkg::sample_t                        load_data,
  input  awg_data_pkg::addr_t    [`AWG_CHANNELS-1:0]   addr_max,
  input  awg_data_pkg::addr_t    [`AWG_CHANNELS-1:0]   read_addr,
  input  logic                   [`AWG_CHANNELS-1:0]   chan_done,
  input  logic                   [`AWG_CHANNELS-1:0]   trig_early,
  input  logic                                         play_active,
  output logic                                         load_done,
  output awg_data_pkg::sample_t  [`AWG_CHANNELS-1:0]   sample_out,
  output logic                   [`AWG_CHANNELS-1:0]   trigger
);
  import awg_data_pkg::*;

  logic                              wr_en;
  sample_t                           wr_data;
  addr_t                             wr_addr;
  chan_t                             wr_chan;
  logic                              wr_full;
  logic                              wr_last;
  logic                              wr_go;
  sample_t                           mem [`AWG_CHANNELS][`AWG_DEPTH];
  sample_t     [`AWG_CHANNELS-1:0]   rd_q;
  sample_t     [`AWG_CHANNELS-1:0]   rd_q2;
  logic        [`AWG_CHANNELS-1:0]   zero_q;
  logic        [`AWG_CHANNELS-1:0]   zero_q2;
  logic        [`AWG_CHANNELS-1:0]   trig_q;
  logic        [`AWG_CHANNELS-1:0]   trig_q2;

  // last address of the last channel ends the load
  assign wr_last = (wr_addr == addr_max[wr_chan]) &&
                   (wr_chan == chan_t'(`AWG_CHANNELS - 1));
  assign wr_go   = load_ready && wr_en && !wr_full;

  ////////////////////////////////////////
  // load path
  ////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    wr_data <= load_data;
  end

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= load_valid & load_ready;
    end
  end

  // write pointer walks channel 0 then channel 1, each to its own depth
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      wr_addr   <= '0;
      wr_chan   <= '0;
      wr_full   <= 1'b0;
      load_done <= 1'b0;
    end else begin
      load_done <= 1'b0;
      if (!load_ready) begin
        // rearm for the next load
        wr_addr <= '0;
        wr_chan <= '0;
        wr_full <= 1'b0;
      end else if (wr_en && !wr_full) begin
        if (wr_addr == addr_max[wr_chan]) begin
          wr_addr <= '0;
          if (wr_last) begin
            wr_full   <= 1'b1;
            load_done <= 1'b1;
          end else begin
            wr_chan <= wr_chan + 1'b1;
          end
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // read path, all channels in parallel
  ////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (wr_go) begin
      mem[wr_chan][wr_addr] <= wr_data;
    end
    for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
      rd_q[ch] <= mem[ch][read_addr[ch]];
    end
    rd_q2 <= rd_q;
  end

  // zero select and trigger ride along with the data, 3 stages from the address
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      zero_q     <= '1;
      zero_q2    <= '1;
      trig_q     <= '0;
      trig_q2    <= '0;
      trigger    <= '0;
      sample_out <= '0;
    end else begin
      zero_q  <= chan_done | {`AWG_CHANNELS{~play_active}};
      zero_q2 <= zero_q;
      trig_q  <= trig_early;
      trig_q2 <= trig_q;
      trigger <= trig_q2;
      for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
        sample_out[ch] <= zero_q2[ch] ? '0 : rd_q2[ch];
      end
    end
  end

endmodule

// ==== hdl/awg_frame_counter.sv ====
// per-channel read address and frame counting with done flags and early triggers
`include "awg_params.svh"

module awg_frame_counter (
  input  logic                                           dac_clk,
  input  logic                                           dma_reset,
  input  logic                                           play_active,
  input  awg_data_pkg::addr_t      [`AWG_CHANNELS-1:0]   addr_max,
  input  awg_data_pkg::burst_t     [`AWG_CHANNELS-1:0]   burst_max,
  input  awg_data_pkg::trig_mode_t [`AWG_CHANNELS-1:0]   trig_mode,
  output awg_data_pkg::addr_t      [`AWG_CHANNELS-1:0]   read_addr,
  output logic                     [`AWG_CHANNELS-1:0]   chan_done,
  output logic                     [`AWG_CHANNELS-1:0]   trig_early,
  output logic                                           play_done
);
  import awg_data_pkg::*;
  import awg_ctrl_pkg::*;

  play_state_t                       run_state;
  burst_t      [`AWG_CHANNELS-1:0]   frame_cnt;
  logic                              all_done;

  // local view of the playback state
  assign run_state = play_active ? PLAY_ACTIVE : PLAY_IDLE;
  assign all_done  = &chan_done;

  ////////////////////////////////////////
  // address and frame counters
  ////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      read_addr <= '0;
      frame_cnt <= '0;
      chan_done <= '0;
    end else begin
      case (run_state)
        // park at address 0 of frame 0 so the next start begins cleanly
        PLAY_IDLE: begin
          read_addr <= '0;
          frame_cnt <= '0;
          chan_done <= '0;
        end
        PLAY_ACTIVE: begin
          for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
            if (read_addr[ch] == addr_max[ch]) begin
              read_addr[ch] <= '0;
              // frame wrap, count up to the last frame of the burst
              if (frame_cnt[ch] == burst_max[ch]) begin
                frame_cnt[ch] <= '0;
                chan_done[ch] <= 1'b1;
              end else begin
                frame_cnt[ch] <= frame_cnt[ch] + 1'b1;
              end
            end else begin
              read_addr[ch] <= read_addr[ch] + 1'b1;
            end
          end
        end
        default: begin
          read_addr <= '0;
          frame_cnt <= '0;
          chan_done <= '0;
        end
      endcase
    end
  end

  // trigger in the same cycle as the address it marks
  always_comb begin
    for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
      trig_early[ch] = 1'b0;
      if ((run_state == PLAY_ACTIVE) && !chan_done[ch] && (read_addr[ch] == '0)) begin
        if (trig_mode[ch] == TRIG_EVERY) begin
          trig_early[ch] = 1'b1;
        end else if ((trig_mode[ch] == TRIG_FIRST) && (frame_cnt[ch] == '0)) begin
          trig_early[ch] = 1'b1;
        end
      end
    end
  end

  // single pulse once every channel has finished its burst
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      play_done <= 1'b0;
    end else begin
      play_done <= (run_state == PLAY_ACTIVE) && all_done && !play_done;
    end
  end

endmodule

// ==== hdl/awg_sequencer.sv ====
// load and playback state machines with the registered channel configuration
`include "awg_params.svh"

module awg_sequencer (
  input  logic                                           dac_clk,
  input  logic                                           dma_reset,
  // config writes, one field per channel
  input  logic                                           depth_valid,
  input  awg_data_pkg::depth_t     [`AWG_CHANNELS-1:0]   depth,
  input  logic                                           trig_valid,
  input  awg_data_pkg::trig_mode_t [`AWG_CHANNELS-1:0]   trig_mode_in,
  input  logic                                           burst_valid,
  input  awg_data_pkg::burst_t     [`AWG_CHANNELS-1:0]   burst,
  // playback commands
  input  logic                                           start,
  input  logic                                           stop,
  // completion from the buffer and the frame counter
  input  logic                                           load_done,
  input  logic                                           play_done,
  output logic                                           config_ready,
  output logic                                           load_ready,
  output logic                                           play_active,
  output awg_data_pkg::addr_t      [`AWG_CHANNELS-1:0]   addr_max,
  output awg_data_pkg::burst_t     [`AWG_CHANNELS-1:0]   burst_max,
  output awg_data_pkg::trig_mode_t [`AWG_CHANNELS-1:0]   trig_mode
);
  import awg_data_pkg::*;
  import awg_ctrl_pkg::*;

  load_state_t load_state;
  play_state_t play_state;
  logic        start_ok;
  logic        stop_ok;

  // config only while idle, waveform words only while accepting
  assign config_ready = (load_state == LOAD_IDLE);
  assign load_ready   = (load_state == LOAD_ACCEPTING);
  assign play_active  = (play_state == PLAY_ACTIVE);

  // commands are ignored while the buffer is being written
  assign start_ok = start & ~load_ready;
  assign stop_ok  = stop & ~load_ready;

  ////////////////////////////////////////
  // load state machine
  ////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      load_state <= LOAD_IDLE;
    end else begin
      case (load_state)
        // a depth write opens the buffer for a new waveform
        LOAD_IDLE:      if (depth_valid) load_state <= LOAD_ACCEPTING;
        LOAD_ACCEPTING: if (load_done) load_state <= LOAD_BLOCKING;
        // hold off new config until the burst ends or is cut short
        LOAD_BLOCKING:  if (stop_ok || play_done) load_state <= LOAD_IDLE;
        default:        load_state <= LOAD_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // playback state machine
  ////////////////////////////////////////
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      play_state <= PLAY_IDLE;
    end else begin
      case (play_state)
        PLAY_IDLE:   if (start_ok) play_state <= PLAY_ACTIVE;
        PLAY_ACTIVE: if (stop_ok || play_done) play_state <= PLAY_IDLE;
        default:     play_state <= PLAY_IDLE;
      endcase
    end
  end

  // config registers keep limits minus one, counters compare against them directly
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      addr_max  <= '0;
      burst_max <= '0;
      trig_mode <= '0;
    end else if (config_ready) begin
      for (int ch = 0; ch < `AWG_CHANNELS; ch++) begin
        if (depth_valid) begin
          addr_max[ch] <= addr_t'(depth[ch] - 1'b1);
        end
        // a zero burst still plays one frame
        if (burst_valid) begin
          burst_max[ch] <= (burst[ch] == '0) ? '0 : burst[ch] - 1'b1;
        end
        if (trig_valid) begin
          trig_mode[ch] <= trig_mode_in[ch];
        end
      end
    end
  end

endmodule

// ==== hdl/awg_ctrl_pkg.sv ====
// state encodings for the load and playback state machines
package awg_ctrl_pkg;

  // idle takes config, accepting takes waveform words, blocking waits for playback
  typedef enum logic [1:0] {
    LOAD_IDLE,
    LOAD_ACCEPTING,
    LOAD_BLOCKING
  } load_state_t;

  // buffers are read out only while active
  typedef enum logic {
    PLAY_IDLE,
    PLAY_ACTIVE
  } play_state_t;

endpackage

// ==== hdl/awg_data_pkg.sv ====
// vector types for the waveform data path and its configuration fields
`include "awg_params.svh"

package awg_data_pkg;

  // one buffer word as sent to the DAC
  typedef logic [`AWG_SAMPLE_WIDTH-1:0] sample_t;

  // address inside one channel buffer
  typedef logic [$clog2(`AWG_DEPTH)-1:0] addr_t;

  // requested frame depth, 1 up to the full buffer, so one bit wider than addr_t
  typedef logic [$clog2(`AWG_DEPTH):0] depth_t;

  // frames per burst, zero is played as a single frame
  typedef logic [`AWG_BURST_WIDTH-1:0] burst_t;

  // trigger mode per channel, value 0 disables the trigger
  typedef logic [1:0] trig_mode_t;
  localparam trig_mode_t TRIG_FIRST = 2'd1;
  localparam trig_mode_t TRIG_EVERY = 2'd2;

  // channel index used by the load write pointer
  typedef logic [$clog2(`AWG_CHANNELS)-1:0] chan_t;

endpackage

// ==== hdl/awg_params.svh ====
// size macros shared by the waveform generator RTL and its testbench
`ifndef AWG_PARAMS_SVH
`define AWG_PARAMS_SVH

////////////////////////////////////////
// channel and buffer geometry
////////////////////////////////////////

// number of independent output channels
`define AWG_CHANNELS 2

// words held by each channel buffer
`define AWG_DEPTH 16

// bits per output word
`define AWG_SAMPLE_WIDTH 16

////////////////////////////////////////
// playback counters
////////////////////////////////////////

// bits of a frames-per-burst count
`define AWG_BURST_WIDTH 8

`endif
